/* logic/bus_ctrl_params.svh */
// bus controller constants for widths, reset values, region bases and idle read data
`ifndef BUS_CTRL_PARAMS_SVH
`define BUS_CTRL_PARAMS_SVH

// cpu and memory data bus width
`define BC_DATA_W 8

// memory address high part, bits 20:12
`define BC_ABH_W 9

// rom block after reset, bit 7 selects the boot rom
`define BC_ROMBLOCK_RST 8'h80

// ram bank after reset
`define BC_RAMBANK_RST 8'h00

// upper byte of the i/o page at 0x9Fxx
`define BC_IO_PAGE 8'h9F

// inverts the msb of the masked ram bank
// so banked ram starts in the middle of sram
`define BC_RAM_XOR 8'h80

// sram region of the rom window, rom starts at sram page 64
`define BC_ROM_SRAM_BASE 2'b01

// mem_abh mark for boot rom cycles, not a real sram address
`define BC_BOOTROM_MARK 9'h1FF

// cpu read value when no device answers
`define BC_UNMAPPED_RD 8'hFF

// extra clk6x cycles of S4H for the ethernet chip
`define BC_ENET_S4_EXT 2'd2

`endif

/* logic/bus_ctrl_pkg.sv */
// bus controller types: access target and the structs passed between pipeline stages
`default_nettype none

package bus_ctrl_pkg;

`include "bus_ctrl_params.svh"

    // device an access goes to, carried down the pipeline like an opcode
    typedef enum logic [3:0] {
        TGT_NONE,
        TGT_SRAM,
        TGT_ROM,
        TGT_BOOTROM,
        TGT_BANKREG,
        TGT_VIA1,
        TGT_VIA2,
        TGT_VERA,
        TGT_AIO,
        TGT_SCRB,
        TGT_ENET
    } bus_tgt_e;

    // decoded access descriptor
    typedef struct packed {
        bus_tgt_e              tgt;
        // full 16-bit cpu address
        logic [15:0]           addr;
        logic [`BC_ABH_W-1:0]  mem_abh;
        // 1 on a read or a suppressed write
        logic                  rwn;
        // cleared for the rom window
        logic                  wr_en;
        logic [1:0]            s4_ext;
    } bus_acc_t;

    // external chip-selects, active low
    typedef struct packed {
        logic sram;
        logic vera;
        logic aio;
        logic enet;
    } ext_csn_t;

    // internal slave requests, active high
    typedef struct packed {
        logic bootrom;
        logic scrb;
        logic via1;
        logic via2;
    } slv_req_t;

endpackage

`default_nettype wire

/* logic/cpu_addr_decode.sv */
// cpu address decode stage, captures the address at setup_cs and emits an access descriptor
`timescale 1ns/100ps
`default_nettype none

`include "bus_ctrl_params.svh"

module cpu_addr_decode
    import bus_ctrl_pkg::*;
(
    input  wire                  clk6x,
    input  wire                  resetn,
    // phaser pulse, phi2 about to rise
    input  wire                  setup_cs_i,
    // 1 for 65C02, 0 for 65C816
    input  wire                  cputype02_i,
    input  wire [15:12]          cpu_abh_i,
    input  wire [11:0]           memcpu_abl_i,
    // carries the bank byte on the 65C816 at this point
    input  wire [`BC_DATA_W-1:0] cpu_db_i,
    input  wire                  cpu_rw_i,
    input  wire                  cpu_vda_i,
    input  wire                  cpu_sync_vpa_i,
    // vector pull, active low
    input  wire                  cpu_vpu_i,
    input  wire                  ignore_cpu_writes_i,
    input  wire [`BC_DATA_W-1:0] rambank_masked_i,
    input  wire [`BC_DATA_W-1:0] romblock_i,
    output bus_acc_t             acc_o,
    output logic                 acc_valid_o,
    output logic [11:0]          memcpu_abl_o,
    output logic [15:0]          slv_addr_o
);

    logic [15:0]           cpu_ab;
    logic [`BC_DATA_W-1:0] cpu_bank;
    logic                  addr_valid;
    logic [4:0]            rom_blk;
    bus_acc_t              acc_d;

    assign cpu_ab = {cpu_abh_i, memcpu_abl_i};

    // 65C02 has no bank byte
    assign cpu_bank = cputype02_i ? 8'h00 : cpu_db_i;

    // 65C816 cycles with neither vda nor vpa are internal operations
    assign addr_valid = cputype02_i | cpu_vda_i | cpu_sync_vpa_i;

    // vector pulls always come from rom block 0
    assign rom_blk = cpu_vpu_i ? romblock_i[4:0] : 5'd0;

    always_comb
    begin
        acc_d.tgt = TGT_NONE;
        acc_d.addr = cpu_ab;
        // low sram page by default
        acc_d.mem_abh = {5'h00, cpu_abh_i};
        acc_d.rwn = cpu_rw_i | ignore_cpu_writes_i;
        acc_d.wr_en = 1'b1;
        acc_d.s4_ext = 2'd0;

        if (!addr_valid)
            acc_d.tgt = TGT_NONE;
        else if (cpu_bank == 8'h00)
        begin
            if (cpu_ab[15:1] == 15'd0)
                // 0x0000 ram bank, 0x0001 rom block
                acc_d.tgt = TGT_BANKREG;
            else if (cpu_abh_i[15:14] == 2'b11)
            begin
                // rom window 0xC000-0xFFFF
                if (romblock_i[7])
                begin
                    acc_d.tgt = TGT_BOOTROM;
                    acc_d.mem_abh = `BC_BOOTROM_MARK;
                end
                else
                begin
                    acc_d.tgt = TGT_ROM;
                    acc_d.mem_abh = {`BC_ROM_SRAM_BASE, rom_blk, cpu_abh_i[13:12]};
                    acc_d.wr_en = 1'b0;
                end
            end
            else if (cpu_abh_i[15:13] == 3'b101)
            begin
                // banked ram 0xA000-0xBFFF
                acc_d.tgt = TGT_SRAM;
                acc_d.mem_abh = {rambank_masked_i ^ `BC_RAM_XOR, cpu_abh_i[12]};
            end
            else if (cpu_ab[15:8] == `BC_IO_PAGE)
            begin
                // i/o page, 16 bytes per device slot
                case (cpu_ab[7:4])
                    4'h0: acc_d.tgt = TGT_VIA1;
                    4'h1: acc_d.tgt = TGT_VIA2;
                    4'h2, 4'h3: acc_d.tgt = TGT_VERA;
                    4'h4: acc_d.tgt = TGT_AIO;
                    4'h5, 4'h6: acc_d.tgt = TGT_SCRB;
                    4'h8:
                    begin
                        // slow part, stretch S4H
                        acc_d.tgt = TGT_ENET;
                        acc_d.s4_ext = `BC_ENET_S4_EXT;
                    end
                    // scratchpad shows the low sram underneath
                    4'hF: acc_d.tgt = TGT_SRAM;
                    default: acc_d.tgt = TGT_NONE;
                endcase
            end
            else
                acc_d.tgt = TGT_SRAM;
        end
        else
        begin
            // non-zero 65C816 bank, linear sram
            acc_d.tgt = TGT_SRAM;
            acc_d.mem_abh = {cpu_bank[4:0], cpu_abh_i};
        end
    end

    // capture descriptor and addresses at the setup pulse
    always_ff @(posedge clk6x)
    begin
        if (setup_cs_i)
        begin
            acc_o <= acc_d;
            memcpu_abl_o <= memcpu_abl_i;
            slv_addr_o <= cpu_ab;
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
            acc_valid_o <= 1'b0;
        else
            acc_valid_o <= setup_cs_i;
    end

endmodule

`default_nettype wire

/* logic/bus_strobe_gen.sv */
// bus strobe stage, drives chip-selects, rd/wr strobes and slave requests for one access
`timescale 1ns/100ps
`default_nettype none

`include "bus_ctrl_params.svh"

module bus_strobe_gen
    import bus_ctrl_pkg::*;
(
    input  wire                  clk6x,
    input  wire                  resetn,
    input  wire bus_acc_t        acc_i,
    input  wire                  acc_valid_i,
    // phaser pulses near the end of phi2
    input  wire                  release_wr_i,
    input  wire                  release_cs_i,
    output bus_acc_t             cur_acc_o,
    output ext_csn_t             ext_csn_o,
    output logic [`BC_ABH_W-1:0] mem_abh_o,
    output logic                 mem_rdn_o,
    output logic                 mem_wrn_o,
    output slv_req_t             slv_req_o,
    output logic                 slv_rwn_o,
    output logic [1:0]           s4_ext_o
);

    ext_csn_t csn_d;
    slv_req_t req_d;
    logic     ext_d;

    // one chip-select or one slave request per target
    always_comb
    begin
        csn_d = '1;
        req_d = '0;
        ext_d = 1'b0;
        case (acc_i.tgt)
            TGT_SRAM, TGT_ROM:
            begin
                csn_d.sram = 1'b0;
                ext_d = 1'b1;
            end
            TGT_VERA:
            begin
                csn_d.vera = 1'b0;
                ext_d = 1'b1;
            end
            TGT_AIO:
            begin
                csn_d.aio = 1'b0;
                ext_d = 1'b1;
            end
            TGT_ENET:
            begin
                csn_d.enet = 1'b0;
                ext_d = 1'b1;
            end
            TGT_BOOTROM: req_d.bootrom = 1'b1;
            TGT_SCRB: req_d.scrb = 1'b1;
            TGT_VIA1: req_d.via1 = 1'b1;
            TGT_VIA2: req_d.via2 = 1'b1;
            // bank registers live in bank_regs, none selects nothing
            default: ;
        endcase
    end

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            cur_acc_o.tgt <= TGT_NONE;
            ext_csn_o <= '1;
            mem_rdn_o <= 1'b1;
            mem_wrn_o <= 1'b1;
            slv_req_o <= '0;
            s4_ext_o <= 2'd0;
        end
        else
        begin
            if (acc_valid_i)
            begin
                cur_acc_o <= acc_i;
                ext_csn_o <= csn_d;
                mem_rdn_o <= ~(ext_d & acc_i.rwn);
                // rom window never gets a write strobe
                mem_wrn_o <= ~(ext_d & ~acc_i.rwn & acc_i.wr_en);
                slv_req_o <= req_d;
                s4_ext_o <= acc_i.s4_ext;
            end
            // release the write early for hold time on the latch
            if (release_wr_i)
                mem_wrn_o <= 1'b1;
            // end of the cpu cycle
            if (release_cs_i)
            begin
                cur_acc_o.tgt <= TGT_NONE;
                ext_csn_o <= '1;
                mem_rdn_o <= 1'b1;
                mem_wrn_o <= 1'b1;
                slv_req_o <= '0;
                s4_ext_o <= 2'd0;
            end
        end
    end

    // memory address and slave direction of the new access
    always_ff @(posedge clk6x)
    begin
        if (acc_valid_i)
        begin
            mem_abh_o <= acc_i.mem_abh;
            slv_rwn_o <= acc_i.rwn;
        end
    end

endmodule

`default_nettype wire

/* logic/bank_regs.sv */
// bank registers, ram bank at 0x0000 and rom block at 0x0001 with boot rom force and clear
`timescale 1ns/100ps
`default_nettype none

`include "bus_ctrl_params.svh"

module bank_regs
    import bus_ctrl_pkg::*;
(
    input  wire                   clk6x,
    input  wire                   resetn,
    input  wire bus_acc_t         cur_acc_i,
    input  wire                   release_wr_i,
    // cpu write data, valid at release_wr
    input  wire [`BC_DATA_W-1:0]  wr_data_i,
    // limits the usable ram banks
    input  wire [`BC_DATA_W-1:0]  rambank_mask_i,
    input  wire                   force_pblrom_i,
    input  wire                   clear_pblrom_i,
    output logic [`BC_DATA_W-1:0] rambank_masked_o,
    output logic [`BC_DATA_W-1:0] romblock_o,
    output logic [`BC_DATA_W-1:0] bankreg_rd_o
);

    logic [`BC_DATA_W-1:0] rambank_r;
    logic                  reg_wr;

    assign reg_wr = release_wr_i & (cur_acc_i.tgt == TGT_BANKREG) & ~cur_acc_i.rwn;

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            rambank_r <= `BC_RAMBANK_RST;
            // start in the boot rom
            romblock_o <= `BC_ROMBLOCK_RST;
        end
        else
        begin
            if (reg_wr && !cur_acc_i.addr[0])
                rambank_r <= wr_data_i;
            if (reg_wr && cur_acc_i.addr[0])
                romblock_o <= wr_data_i;
            // force into the boot rom
            if (force_pblrom_i)
                romblock_o[7] <= 1'b1;
            // clear wins over force
            if (clear_pblrom_i)
                romblock_o[7:6] <= 2'b00;
        end
    end

    // masked bank is precomputed, one cycle behind
    always_ff @(posedge clk6x)
    begin
        rambank_masked_o <= rambank_r & rambank_mask_i;
    end

    // readback by address bit 0
    assign bankreg_rd_o = cur_acc_i.addr[0] ? romblock_o : rambank_r;

endmodule

`default_nettype wire

/* logic/read_data_mux.sv */
// read data stage, registers the cpu read byte and holds cpu write data for the memory bus
`timescale 1ns/100ps
`default_nettype none

`include "bus_ctrl_params.svh"

module read_data_mux
    import bus_ctrl_pkg::*;
(
    input  wire                   clk6x,
    input  wire                   resetn,
    input  wire bus_acc_t         cur_acc_i,
    input  wire                   mem_rdn_i,
    input  wire [`BC_DATA_W-1:0]  mem_db_i,
    input  wire [`BC_DATA_W-1:0]  bankreg_rd_i,
    input  wire [`BC_DATA_W-1:0]  slv_data_i,
    input  wire [`BC_DATA_W-1:0]  cpu_db_i,
    input  wire                   cphi2_i,
    output logic [`BC_DATA_W-1:0] cpu_db_o,
    output logic [`BC_DATA_W-1:0] mem_db_o
);

    logic [`BC_DATA_W-1:0] db_hold_r;
    logic                  slv_sel;

    assign slv_sel = (cur_acc_i.tgt == TGT_BOOTROM) | (cur_acc_i.tgt == TGT_SCRB)
                   | (cur_acc_i.tgt == TGT_VIA1) | (cur_acc_i.tgt == TGT_VIA2);

    // external read first, then bank registers, then internal slaves
    always_ff @(posedge clk6x)
    begin
        if (!resetn)
            cpu_db_o <= `BC_UNMAPPED_RD;
        else if (!mem_rdn_i)
            cpu_db_o <= mem_db_i;
        else if (cur_acc_i.tgt == TGT_BANKREG)
            cpu_db_o <= bankreg_rd_i;
        else if (slv_sel)
            cpu_db_o <= slv_data_i;
        else
            cpu_db_o <= `BC_UNMAPPED_RD;
    end

    // the 65C816 puts its bank byte on the data bus while phi2 is low
    // so the last phi2-high value is held for write hold time
    always_ff @(posedge clk6x)
    begin
        if (cphi2_i)
            db_hold_r <= cpu_db_i;
    end

    assign mem_db_o = cphi2_i ? cpu_db_i : db_hold_r;

endmodule

`default_nettype wire

/* logic/bus_ctrl_top.sv */
// external bus controller top, cpu side decode, strobes, bank registers and read data
`timescale 1ns/100ps
`default_nettype none

`include "bus_ctrl_params.svh"

module bus_ctrl_top
    import bus_ctrl_pkg::*;
(
    input  wire                   clk6x,
    input  wire                   resetn,
    input  wire                   cputype02_i,
    // cpu bus
    input  wire [15:12]           cpu_abh_i,
    input  wire [11:0]            memcpu_abl_i,
    input  wire [`BC_DATA_W-1:0]  cpu_db_i,
    output logic [`BC_DATA_W-1:0] cpu_db_o,
    input  wire                   cpu_rw_i,
    input  wire                   cpu_vda_i,
    input  wire                   cpu_sync_vpa_i,
    input  wire                   cpu_vpu_i,
    input  wire                   ignore_cpu_writes_i,
    // phaser
    input  wire                   setup_cs_i,
    input  wire                   release_wr_i,
    input  wire                   release_cs_i,
    input  wire                   cphi2_i,
    output logic [1:0]            s4_ext_o,
    // memory bus
    output logic [`BC_ABH_W-1:0]  mem_abh_o,
    output logic [11:0]           memcpu_abl_o,
    input  wire [`BC_DATA_W-1:0]  mem_db_i,
    output logic [`BC_DATA_W-1:0] mem_db_o,
    output logic                  mem_rdn_o,
    output logic                  mem_wrn_o,
    output ext_csn_t              ext_csn_o,
    // internal slaves
    output logic [15:0]           slv_addr_o,
    output logic [`BC_DATA_W-1:0] slv_datawr_o,
    input  wire [`BC_DATA_W-1:0]  slv_data_i,
    output slv_req_t              slv_req_o,
    output logic                  slv_rwn_o,
    // bank control
    input  wire [`BC_DATA_W-1:0]  rambank_mask_i,
    input  wire                   force_pblrom_i,
    input  wire                   clear_pblrom_i,
    output logic [`BC_DATA_W-1:0] romblock_o
);

    bus_acc_t              acc;
    logic                  acc_valid;
    bus_acc_t              cur_acc;
    logic [`BC_DATA_W-1:0] rambank_masked;
    logic [`BC_DATA_W-1:0] bankreg_rd;

    // cpu write data straight through, valid at the end of the cycle
    assign slv_datawr_o = cpu_db_i;

    cpu_addr_decode decode_i (
        .clk6x               (clk6x),
        .resetn              (resetn),
        .setup_cs_i          (setup_cs_i),
        .cputype02_i         (cputype02_i),
        .cpu_abh_i           (cpu_abh_i),
        .memcpu_abl_i        (memcpu_abl_i),
        .cpu_db_i            (cpu_db_i),
        .cpu_rw_i            (cpu_rw_i),
        .cpu_vda_i           (cpu_vda_i),
        .cpu_sync_vpa_i      (cpu_sync_vpa_i),
        .cpu_vpu_i           (cpu_vpu_i),
        .ignore_cpu_writes_i (ignore_cpu_writes_i),
        .rambank_masked_i    (rambank_masked),
        .romblock_i          (romblock_o),
        .acc_o               (acc),
        .acc_valid_o         (acc_valid),
        .memcpu_abl_o        (memcpu_abl_o),
        .slv_addr_o          (slv_addr_o)
    );

    bus_strobe_gen strobe_i (
        .clk6x        (clk6x),
        .resetn       (resetn),
        .acc_i        (acc),
        .acc_valid_i  (acc_valid),
        .release_wr_i (release_wr_i),
        .release_cs_i (release_cs_i),
        .cur_acc_o    (cur_acc),
        .ext_csn_o    (ext_csn_o),
        .mem_abh_o    (mem_abh_o),
        .mem_rdn_o    (mem_rdn_o),
        .mem_wrn_o    (mem_wrn_o),
        .slv_req_o    (slv_req_o),
        .slv_rwn_o    (slv_rwn_o),
        .s4_ext_o     (s4_ext_o)
    );

    bank_regs bank_i (
        .clk6x            (clk6x),
        .resetn           (resetn),
        .cur_acc_i        (cur_acc),
        .release_wr_i     (release_wr_i),
        .wr_data_i        (cpu_db_i),
        .rambank_mask_i   (rambank_mask_i),
        .force_pblrom_i   (force_pblrom_i),
        .clear_pblrom_i   (clear_pblrom_i),
        .rambank_masked_o (rambank_masked),
        .romblock_o       (romblock_o),
        .bankreg_rd_o     (bankreg_rd)
    );

    read_data_mux rdmux_i (
        .clk6x        (clk6x),
        .resetn       (resetn),
        .cur_acc_i    (cur_acc),
        .mem_rdn_i    (mem_rdn_o),
        .mem_db_i     (mem_db_i),
        .bankreg_rd_i (bankreg_rd),
        .slv_data_i   (slv_data_i),
        .cpu_db_i     (cpu_db_i),
        .cphi2_i      (cphi2_i),
        .cpu_db_o     (cpu_db_o),
        .mem_db_o     (mem_db_o)
    );

endmodule

`default_nettype wire

/* verification/bus_ctrl_tb.sv */
// bus controller testbench, runs table-driven cpu bus cycles and compares strobes and read data
`timescale 1ns/100ps
`default_nettype none

`include "bus_ctrl_params.svh"

module bus_ctrl_tb
    import bus_ctrl_pkg::*;
;

    // release pulses must take effect within this many cycles
    localparam int REL_LIMIT = 2;
    // constant answer of the internal slaves
    localparam logic [7:0] SLV_DATA = 8'h5A;

    // one bus cycle with its expected responses
    typedef struct packed {
        logic                 cpu02;
        logic [15:0]          addr;
        // bank byte on the 65C816, write data on the 65C02
        logic [7:0]           db;
        logic                 rw;
        logic                 vda;
        logic                 vpa;
        logic                 vpu;
        logic                 ign;
        // pulse clear_pblrom before the cycle
        logic                 clr;
        ext_csn_t             csn;
        slv_req_t             req;
        logic [`BC_ABH_W-1:0] abh;
        logic                 rdn;
        logic                 wrn;
        logic [1:0]           s4;
        logic [7:0]           rd;
        // expect the random mem_db_i value instead of rd
        logic                 rd_mem;
    } cycle_vec_t;

    logic clk6x, resetn, cputype02_i, cpu_rw_i, cpu_vda_i, cpu_sync_vpa_i, cpu_vpu_i;
    logic ignore_cpu_writes_i, setup_cs_i, release_wr_i, release_cs_i, cphi2_i;
    logic force_pblrom_i, clear_pblrom_i, mem_rdn_o, mem_wrn_o, slv_rwn_o;
    logic [15:12] cpu_abh_i;
    logic [11:0] memcpu_abl_i, memcpu_abl_o;
    logic [7:0] cpu_db_i, cpu_db_o, mem_db_i, mem_db_o, slv_data_i, slv_datawr_o;
    logic [7:0] rambank_mask_i, romblock_o;
    logic [1:0] s4_ext_o;
    logic [`BC_ABH_W-1:0] mem_abh_o;
    logic [15:0] slv_addr_o;
    ext_csn_t ext_csn_o;
    slv_req_t slv_req_o;

    cycle_vec_t vec_q[$];
    integer seed, idx, test_errs, tests_run, tests_failed;
    logic timed_out;
    logic [7:0] cur_mem_db;

    bus_ctrl_top dut_i (.*);

    initial
    begin
        clk6x = 1'b0;
        forever #5 clk6x = ~clk6x;
    end

    // inputs change 1 ns after the rising edge, outputs are read there too
    task next_edge();
    begin
        @(posedge clk6x);
        #1;
    end
    endtask

    task add_vec(input logic cpu02, input logic [15:0] addr, input logic [7:0] db,
                 input logic rw, input logic vda, input logic vpa, input logic vpu,
                 input logic ign, input logic clr, input ext_csn_t csn, input slv_req_t req,
                 input logic [`BC_ABH_W-1:0] abh, input logic rdn, input logic wrn,
                 input logic [1:0] s4, input logic [7:0] rd, input logic rd_mem);
        cycle_vec_t v;
    begin
        v = {cpu02, addr, db, rw, vda, vpa, vpu, ign, clr, csn, req, abh, rdn, wrn, s4,
             rd, rd_mem};
        vec_q.push_back(v);
    end
    endtask

    task check_csn(input ext_csn_t got, input ext_csn_t exp, input string what);
    begin
        if (got !== exp)
        begin
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
            test_errs = test_errs + 1;
        end
    end
    endtask

    task check_req(input slv_req_t got, input slv_req_t exp, input string what);
    begin
        if (got !== exp)
        begin
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
            test_errs = test_errs + 1;
        end
    end
    endtask

    task check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    begin
        if (got !== exp)
        begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            test_errs = test_errs + 1;
        end
    end
    endtask

    task check_abh(input logic [`BC_ABH_W-1:0] got, input logic [`BC_ABH_W-1:0] exp,
                   input string what);
    begin
        if (got !== exp)
        begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            test_errs = test_errs + 1;
        end
    end
    endtask

    task check_addr(input logic [15:0] got, input logic [15:0] exp, input string what);
    begin
        if (got !== exp)
        begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            test_errs = test_errs + 1;
        end
    end
    endtask

    task check_strobe(input logic got, input logic exp, input string what);
    begin
        if (got !== exp)
        begin
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
            test_errs = test_errs + 1;
        end
    end
    endtask

    task check_s4(input logic [1:0] got, input logic [1:0] exp, input string what);
    begin
        if (got !== exp)
        begin
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
            test_errs = test_errs + 1;
        end
    end
    endtask

    task finish_test(input string label);
    begin
        tests_run = tests_run + 1;
        if (test_errs == 0)
            $display("test %0d %s ok", tests_run, label);
        else
        begin
            $display("test %0d %s had %0d errors", tests_run, label, test_errs);
            tests_failed = tests_failed + 1;
        end
        test_errs = 0;
    end
    endtask

    // setup phase, then strobes two cycles later and read data one cycle after that
    task run_access(input cycle_vec_t v);
        integer rnd;
    begin
        rnd = $random(seed);
        cur_mem_db = rnd[7:0];
        if (v.clr)
        begin
            clear_pblrom_i = 1'b1;
            next_edge();
            clear_pblrom_i = 1'b0;
        end
        cputype02_i = v.cpu02;
        cpu_abh_i = v.addr[15:12];
        memcpu_abl_i = v.addr[11:0];
        cpu_db_i = v.db;
        cpu_rw_i = v.rw;
        cpu_vda_i = v.vda;
        cpu_sync_vpa_i = v.vpa;
        cpu_vpu_i = v.vpu;
        ignore_cpu_writes_i = v.ign;
        mem_db_i = cur_mem_db;
        setup_cs_i = 1'b1;
        next_edge();
        setup_cs_i = 1'b0;
        cphi2_i = 1'b1;
        // live cpu data on the memory bus before the hold register catches up
        @(negedge clk6x);
        check_byte(mem_db_o, v.db, "memory write data in phi2 high");
        next_edge();
        check_csn(ext_csn_o, v.csn, "chip-selects");
        check_req(slv_req_o, v.req, "slave requests");
        check_strobe(mem_rdn_o, v.rdn, "mem_rdn");
        check_strobe(mem_wrn_o, v.wrn, "mem_wrn");
        check_s4(s4_ext_o, v.s4, "s4 extension");
        check_addr(slv_addr_o, v.addr, "slave address");
        check_addr({4'h0, memcpu_abl_o}, {4'h0, v.addr[11:0]}, "memory low address");
        // slaves see an ignored write as a read
        check_strobe(slv_rwn_o, v.rw | v.ign, "slave rwn");
        // memory address only matters when sram or the boot rom is addressed
        if (!v.csn.sram || v.req.bootrom)
            check_abh(mem_abh_o, v.abh, "mem_abh");
        next_edge();
        check_byte(cpu_db_o, v.rd_mem ? cur_mem_db : v.rd, "cpu read data");
    end
    endtask

    task end_write();
        integer n;
    begin
        release_wr_i = 1'b1;
        next_edge();
        release_wr_i = 1'b0;
        n = 0;
        while (mem_wrn_o !== 1'b1 && n < REL_LIMIT)
        begin
            next_edge();
            n = n + 1;
        end
        if (mem_wrn_o !== 1'b1)
        begin
            $display("timeout: write strobe still low %0d cycles after release_wr", REL_LIMIT);
            test_errs = test_errs + 1;
            timed_out = 1'b1;
        end
    end
    endtask

    task end_access(input cycle_vec_t v);
        integer n;
    begin
        release_cs_i = 1'b1;
        next_edge();
        release_cs_i = 1'b0;
        cphi2_i = 1'b0;
        // the cpu bus moves on once phi2 falls
        cpu_db_i = ~v.db;
        n = 0;
        while (ext_csn_o !== 4'b1111 && n < REL_LIMIT)
        begin
            next_edge();
            n = n + 1;
        end
        if (ext_csn_o !== 4'b1111)
        begin
            $display("timeout: chip-selects still active %0d cycles after release_cs",
                     REL_LIMIT);
            test_errs = test_errs + 1;
            timed_out = 1'b1;
        end
        else
        begin
            check_req(slv_req_o, 4'b0000, "slave requests after release");
            check_strobe(mem_rdn_o, 1'b1, "mem_rdn after release");
            check_strobe(mem_wrn_o, 1'b1, "mem_wrn after release");
            check_s4(s4_ext_o, 2'd0, "s4 extension after release");
            next_edge();
            check_byte(mem_db_o, v.db, "memory write data held in phi2 low");
            check_byte(slv_datawr_o, ~v.db, "slave write data");
        end
    end
    endtask

    task load_table();
    begin
        // cpu02 addr db rw vda vpa vpu ign clr | csn req abh rdn wrn s4 rd rd_mem
        add_vec(1, 16'hC000, 8'h00, 1, 0, 0, 1, 0, 0, 4'b1111, 4'b1000, 9'h1FF, 1, 1, 0, SLV_DATA, 0);
        // bank registers, ram bank 5 then rom block 3 after clear
        add_vec(1, 16'h0000, 8'h05, 0, 0, 0, 1, 0, 0, 4'b1111, 4'b0000, 9'h000, 1, 1, 0, 8'h00, 0);
        add_vec(1, 16'hA000, 8'h00, 1, 0, 0, 1, 0, 0, 4'b0111, 4'b0000, 9'h10A, 0, 1, 0, 8'hFF, 1);
        add_vec(1, 16'h0001, 8'h03, 0, 0, 0, 1, 0, 1, 4'b1111, 4'b0000, 9'h000, 1, 1, 0, 8'h00, 0);
        add_vec(1, 16'hC000, 8'h00, 1, 0, 0, 1, 0, 0, 4'b0111, 4'b0000, 9'h08C, 0, 1, 0, 8'hFF, 1);
        // vector pull from block 0
        add_vec(1, 16'hFFFC, 8'h00, 1, 0, 0, 0, 0, 0, 4'b0111, 4'b0000, 9'h083, 0, 1, 0, 8'hFF, 1);
        add_vec(1, 16'hC000, 8'h77, 0, 0, 0, 1, 0, 0, 4'b0111, 4'b0000, 9'h08C, 1, 1, 0, 8'hFF, 0);
        // i/o page slots
        add_vec(1, 16'h9F00, 8'h00, 1, 0, 0, 1, 0, 0, 4'b1111, 4'b0010, 9'h000, 1, 1, 0, SLV_DATA, 0);
        add_vec(1, 16'h9F10, 8'h00, 1, 0, 0, 1, 0, 0, 4'b1111, 4'b0001, 9'h000, 1, 1, 0, SLV_DATA, 0);
        add_vec(1, 16'h9F20, 8'h00, 1, 0, 0, 1, 0, 0, 4'b1011, 4'b0000, 9'h000, 0, 1, 0, 8'hFF, 1);
        add_vec(1, 16'h9F30, 8'h00, 1, 0, 0, 1, 0, 0, 4'b1011, 4'b0000, 9'h000, 0, 1, 0, 8'hFF, 1);
        add_vec(1, 16'h9F40, 8'h00, 1, 0, 0, 1, 0, 0, 4'b1101, 4'b0000, 9'h000, 0, 1, 0, 8'hFF, 1);
        add_vec(1, 16'h9F50, 8'h00, 1, 0, 0, 1, 0, 0, 4'b1111, 4'b0100, 9'h000, 1, 1, 0, SLV_DATA, 0);
        add_vec(1, 16'h9F60, 8'h00, 1, 0, 0, 1, 0, 0, 4'b1111, 4'b0100, 9'h000, 1, 1, 0, SLV_DATA, 0);
        add_vec(1, 16'h9F80, 8'h00, 1, 0, 0, 1, 0, 0, 4'b1110, 4'b0000, 9'h000, 0, 1, 2, 8'hFF, 1);
        add_vec(1, 16'h9FF0, 8'h00, 1, 0, 0, 1, 0, 0, 4'b0111, 4'b0000, 9'h009, 0, 1, 0, 8'hFF, 1);
        add_vec(1, 16'h9F70, 8'h00, 1, 0, 0, 1, 0, 0, 4'b1111, 4'b0000, 9'h000, 1, 1, 0, 8'hFF, 0);
        // 65C816 linear sram, no valid address, vpa only, ignored and real write
        add_vec(0, 16'h3456, 8'h12, 1, 1, 0, 1, 0, 0, 4'b0111, 4'b0000, 9'h123, 0, 1, 0, 8'hFF, 1);
        add_vec(0, 16'h2000, 8'h00, 1, 0, 0, 1, 0, 0, 4'b1111, 4'b0000, 9'h000, 1, 1, 0, 8'hFF, 0);
        add_vec(0, 16'hB000, 8'h00, 1, 0, 1, 1, 0, 0, 4'b0111, 4'b0000, 9'h10B, 0, 1, 0, 8'hFF, 1);
        add_vec(0, 16'h1000, 8'h01, 0, 1, 0, 1, 1, 0, 4'b0111, 4'b0000, 9'h011, 0, 1, 0, 8'hFF, 1);
        add_vec(0, 16'h1000, 8'h01, 0, 1, 0, 1, 0, 0, 4'b0111, 4'b0000, 9'h011, 1, 0, 0, 8'hFF, 0);
    end
    endtask

    initial
    begin
        seed = 32'h6145;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        resetn = 1'b0;
        cputype02_i = 1'b1;
        cpu_abh_i = 4'h0;
        memcpu_abl_i = 12'h000;
        cpu_db_i = 8'h00;
        cpu_rw_i = 1'b1;
        cpu_vda_i = 1'b0;
        cpu_sync_vpa_i = 1'b0;
        cpu_vpu_i = 1'b1;
        ignore_cpu_writes_i = 1'b0;
        setup_cs_i = 1'b0;
        release_wr_i = 1'b0;
        release_cs_i = 1'b0;
        cphi2_i = 1'b0;
        mem_db_i = 8'h00;
        slv_data_i = SLV_DATA;
        rambank_mask_i = 8'h0F;
        force_pblrom_i = 1'b0;
        clear_pblrom_i = 1'b0;
        load_table();
        repeat (4) next_edge();
        resetn = 1'b1;
        next_edge();
        check_csn(ext_csn_o, 4'b1111, "chip-selects after reset");
        check_req(slv_req_o, 4'b0000, "slave requests after reset");
        check_strobe(mem_rdn_o, 1'b1, "mem_rdn after reset");
        check_strobe(mem_wrn_o, 1'b1, "mem_wrn after reset");
        // the system starts in the boot rom
        check_byte(romblock_o, 8'h80, "romblock after reset");
        finish_test("reset state");
        for (idx = 0; idx < vec_q.size() && !timed_out; idx = idx + 1)
        begin
            run_access(vec_q[idx]);
            end_write();
            if (!timed_out)
                end_access(vec_q[idx]);
            finish_test($sformatf("cycle %0d at %h", idx, vec_q[idx].addr));
        end
        if (!timed_out)
        begin
            // force sets bit 7 on top of block 3
            force_pblrom_i = 1'b1;
            next_edge();
            force_pblrom_i = 1'b0;
            check_byte(romblock_o, 8'h83, "romblock after force");
            finish_test("boot rom force");
            // clear has priority over force
            force_pblrom_i = 1'b1;
            clear_pblrom_i = 1'b1;
            next_edge();
            force_pblrom_i = 1'b0;
            clear_pblrom_i = 1'b0;
            check_byte(romblock_o, 8'h03, "romblock after force and clear");
            finish_test("boot rom clear priority");
        end
        $display("summary: run %0d passed %0d failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && !timed_out)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* bus_ctrl.f */
+incdir+logic
logic/bus_ctrl_pkg.sv
logic/cpu_addr_decode.sv
logic/bus_strobe_gen.sv
logic/bank_regs.sv
logic/read_data_mux.sv
logic/bus_ctrl_top.sv
verification/bus_ctrl_tb.sv
